//--- cache_ram.sv
`timescale 1ns/100ps

module cache_ram
	import icache_pkg::*;
#(
	parameter int DEPTH = SETS,
	parameter type dtype = logic
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   we,
	input  index_t addr,
	input  dtype   din,
	output dtype   dout
);

	dtype mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= din;
		end
	end

	// write-first, new value visible on the next cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			dout <= '0;
		end else if (we) begin
			dout <= din;
		end else begin
			dout <= mem[addr];
		end
	end

endmodule

//--- hit_select.sv
`timescale 1ns/100ps

module hit_select
	import icache_pkg::*;
#(
	parameter int WAYS = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  tag_entry_t [WAYS-1:0]  tags,
	input  line_t [WAYS-1:0]       lines,
	input  fetch_addr_t            pipe_addr,
	input  logic                   pipe_valid,
	input  logic                   deliver,
	output logic                   miss,
	output logic [WAYS-1:0]        hit_way_onehot,
	output fetch_rsp_t             rsp
);

	logic [WAYS-1:0] hit;
	word_t [WAYS-1:0] word_q;
	logic rsp_valid_q;

	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			hit[i] = tags[i].valid && (tags[i].tag == pipe_addr.f.tag);
		end
	end

	assign miss = pipe_valid && !(|hit);

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_way_onehot <= '0;
			rsp_valid_q <= 1'b0;
		end else begin
			hit_way_onehot <= hit;
			rsp_valid_q <= pipe_valid && deliver && !miss;
		end
	end

	// addressed word of every way, picked after the edge
	always_ff @(posedge clk) begin
		for (int i = 0; i < WAYS; i++) begin
			word_q[i] <= lines[i][pipe_addr.f.offset];
		end
	end

	always_comb begin
		rsp.valid = rsp_valid_q;
		rsp.data = '0;
		for (int i = 0; i < WAYS; i++) begin
			rsp.data |= {WORD_W{hit_way_onehot[i]}} & word_q[i];
		end
	end

	// a line must never be filled into two ways
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
		pipe_valid |-> $onehot0(hit))
		else $error("hit_select: tag %h hits in several ways", pipe_addr.f.tag);

endmodule

//--- icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl
	import icache_pkg::*;
#(
	parameter int WAYS = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            req_valid,
	input  fetch_addr_t     req_addr,
	output logic            req_ready,
	input  logic            miss,
	input  logic            refill_done,
	output mem_req_t        mem_req,
	input  mem_rsp_t        mem_rsp,
	output index_t          ram_addr,
	output logic [WAYS-1:0] tag_we,
	output logic [WAYS-1:0] data_we,
	output tag_entry_t      tag_wdata,
	output fetch_addr_t     pipe_addr,
	output logic            pipe_valid,
	output logic            refill_en,
	output logic            deliver
);

	localparam int WAY_W = $clog2(WAYS);

	typedef enum logic [2:0] {
		INVALIDATING,
		IDLE,
		WAIT_AR,
		RECEIVING,
		FINISH
	} state_t;

	state_t state;
	state_t state_d;
	index_t inv_cnt;
	logic [7:0] lfsr;
	logic [WAY_W-1:0] victim;

	if (WAYS < 2 || WAYS > 8 || (WAYS & (WAYS - 1)) != 0) begin : g_ways_check
		$error("icache_ctrl: WAYS must be 2, 4 or 8");
	end

	assign victim = lfsr[WAY_W-1:0];

	// pipeline only moves in IDLE or FINISH, and stops on a miss
	assign deliver = (state == IDLE) || (state == FINISH);
	assign req_ready = deliver && !miss;
	assign refill_en = (state == RECEIVING);

	always_comb begin
		state_d = state;
		case (state)
			INVALIDATING: begin
				if (inv_cnt == index_t'(SETS - 1)) begin
					state_d = IDLE;
				end
			end
			IDLE, FINISH: begin
				state_d = miss ? WAIT_AR : IDLE;
			end
			WAIT_AR: begin
				if (mem_rsp.ar_ready) begin
					state_d = RECEIVING;
				end
			end
			RECEIVING: begin
				if (refill_done) begin
					state_d = FINISH;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// sweep, new request, or the held pipeline address
	always_comb begin
		if (state == INVALIDATING) begin
			ram_addr = inv_cnt;
		end else if (req_ready) begin
			ram_addr = req_addr.f.index;
		end else begin
			ram_addr = pipe_addr.f.index;
		end
	end

	always_comb begin
		tag_we = '0;
		data_we = '0;
		tag_wdata.valid = 1'b1;
		tag_wdata.tag = pipe_addr.f.tag;
		if (state == INVALIDATING) begin
			tag_we = '1;
			tag_wdata = '0;
		end else if (refill_done) begin
			tag_we[victim] = 1'b1;
			data_we[victim] = 1'b1;
		end
	end

	// line-aligned burst of one full line
	always_comb begin
		mem_req.ar_valid = (state == WAIT_AR);
		mem_req.ar_addr = {pipe_addr.f.tag, pipe_addr.f.index, {(OFFSET_W + 2){1'b0}}};
		mem_req.ar_len = 8'(LINE_WORDS - 1);
		mem_req.r_ready = (state == RECEIVING);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= INVALIDATING;
			inv_cnt <= '0;
			lfsr <= 8'hb5;
			pipe_valid <= 1'b0;
		end else begin
			state <= state_d;
			if (state == INVALIDATING) begin
				inv_cnt <= inv_cnt + 1'b1;
			end
			// x^8 + x^6 + x^5 + x^4 + 1
			if (refill_done) begin
				lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
			end
			if (req_ready) begin
				pipe_valid <= req_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_ready) begin
			pipe_addr <= req_addr;
		end
	end

	a_idle_no_write: assert property (@(posedge clk) disable iff (rst)
		(state == IDLE) |-> (tag_we == '0) && (data_we == '0))
		else $error("icache_ctrl: RAM write while idle");

	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req.ar_valid && !mem_rsp.ar_ready |=>
			mem_req.ar_valid && $stable(mem_req.ar_addr))
		else $error("icache_ctrl: AR request dropped before ar_ready");

endmodule

//--- icache_pkg.sv
package icache_pkg;

	// cache geometry
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;
	localparam int LINE_WORDS = 8;
	localparam int SETS = 64;
	localparam int OFFSET_W = 3;
	localparam int INDEX_W = 6;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - 2;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	// fetch address split into its cache fields
	typedef struct packed {
		tag_t tag;
		index_t index;
		offset_t offset;
		logic [1:0] byte_sel;
	} fetch_fields_t;

	typedef union packed {
		word_t raw;
		fetch_fields_t f;
	} fetch_addr_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

	// refill port, cache to memory
	typedef struct packed {
		logic ar_valid;
		word_t ar_addr;
		logic [7:0] ar_len;
		logic r_ready;
	} mem_req_t;

	// refill port, memory to cache
	typedef struct packed {
		logic ar_ready;
		logic r_valid;
		word_t r_data;
		logic r_last;
	} mem_rsp_t;

	// no ready, the fetch stage always takes the word
	typedef struct packed {
		logic valid;
		word_t data;
	} fetch_rsp_t;

endpackage

//--- icache_top.sv
`timescale 1ns/100ps

module icache_top
	import icache_pkg::*;
#(
	parameter int WAYS = 4
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        req_valid,
	input  fetch_addr_t req_addr,
	output logic        req_ready,
	output fetch_rsp_t  rsp,
	output mem_req_t    mem_req,
	input  mem_rsp_t    mem_rsp
);

	tag_entry_t [WAYS-1:0] tag_rdata;
	line_t [WAYS-1:0] line_rdata;
	tag_entry_t tag_wdata;
	line_t refill_line;
	logic [WAYS-1:0] tag_we;
	logic [WAYS-1:0] data_we;
	index_t ram_addr;
	fetch_addr_t pipe_addr;
	logic pipe_valid;
	logic miss;
	logic refill_done;
	logic refill_en;
	logic deliver;

	icache_ctrl #(
		.WAYS (WAYS)
	) u_icache_ctrl (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_addr    (req_addr),
		.req_ready   (req_ready),
		.miss        (miss),
		.refill_done (refill_done),
		.mem_req     (mem_req),
		.mem_rsp     (mem_rsp),
		.ram_addr    (ram_addr),
		.tag_we      (tag_we),
		.data_we     (data_we),
		.tag_wdata   (tag_wdata),
		.pipe_addr   (pipe_addr),
		.pipe_valid  (pipe_valid),
		.refill_en   (refill_en),
		.deliver     (deliver)
	);

	refill_buffer u_refill_buffer (
		.clk     (clk),
		.rst     (rst),
		.enable  (refill_en),
		.mem_rsp (mem_rsp),
		.line    (refill_line),
		.done    (refill_done)
	);

	hit_select #(
		.WAYS (WAYS)
	) u_hit_select (
		.clk            (clk),
		.rst            (rst),
		.tags           (tag_rdata),
		.lines          (line_rdata),
		.pipe_addr      (pipe_addr),
		.pipe_valid     (pipe_valid),
		.deliver        (deliver),
		.miss           (miss),
		.hit_way_onehot (),
		.rsp            (rsp)
	);

	// one tag array and one line array per way
	for (genvar i = 0; i < WAYS; i++) begin : g_way
		cache_ram #(
			.DEPTH (SETS),
			.dtype (tag_entry_t)
		) u_tag_ram (
			.clk  (clk),
			.rst  (rst),
			.we   (tag_we[i]),
			.addr (ram_addr),
			.din  (tag_wdata),
			.dout (tag_rdata[i])
		);

		cache_ram #(
			.DEPTH (SETS),
			.dtype (line_t)
		) u_line_ram (
			.clk  (clk),
			.rst  (rst),
			.we   (data_we[i]),
			.addr (ram_addr),
			.din  (refill_line),
			.dout (line_rdata[i])
		);
	end

endmodule

//--- refill_buffer.sv
`timescale 1ns/100ps

module refill_buffer
	import icache_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     enable,
	input  mem_rsp_t mem_rsp,
	output line_t    line,
	output logic     done
);

	logic [OFFSET_W-1:0] beat_cnt;
	line_t words_q;
	logic beat;

	// r_ready is held for the whole refill, so any r_valid is a beat
	assign beat = enable && mem_rsp.r_valid;
	assign done = beat && mem_rsp.r_last;

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (done) begin
			beat_cnt <= '0;
		end else if (beat) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (beat) begin
			words_q[beat_cnt] <= mem_rsp.r_data;
		end
	end

	// last word comes straight from the bus
	always_comb begin
		line = words_q;
		line[LINE_WORDS-1] = mem_rsp.r_data;
	end

	a_last_on_eighth: assert property (@(posedge clk) disable iff (rst)
		beat |-> (mem_rsp.r_last == (beat_cnt == OFFSET_W'(LINE_WORDS - 1))))
		else $error("refill_buffer: r_last not on beat %0d", LINE_WORDS);

endmodule

//--- run.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_icache -Mdir obj_dir -o tb_icache_sim -f tb.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_icache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1

//--- tb.f
icache_pkg.sv
cache_ram.sv
refill_buffer.sv
hit_select.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

//--- tb_icache.sv
`timescale 1ns/100ps

module tb_icache
	import icache_pkg::*;
();

	localparam int WAYS = 4;
	localparam int TIMEOUT = 2000;
	localparam word_t COLD_ADDR = 32'h0000_1234;
	localparam word_t RAND_BASE = 32'h0020_0000;
	localparam index_t CONFLICT_INDEX = 6'h2a;

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	fetch_addr_t req_addr;
	logic req_ready;
	fetch_rsp_t rsp;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp = '0;

	int errors = 0;
	int rsp_errors = 0;
	int cycle = 0;
	int acc_cnt = 0;
	int rsp_cnt = 0;
	int ar_cnt = 0;
	logic stall_en = 1'b0;
	logic timed_out = 1'b0;
	logic [31:0] addr_lfsr = 32'h8f2d832f;
	logic [31:0] stall_lfsr = 32'h8f2d832f;
	word_t exp_q[$];
	int acc_q[$];
	int lat_q[$];
	mem_req_t ar_log[$];
	word_t rsp_addr;

	// memory model state
	logic busy = 1'b0;
	int beat = 0;
	int burst_len = 0;
	word_t burst_addr = '0;
	mem_req_t ar_req;
	logic ar_fire;
	logic r_fire;
	logic stall;

	icache_top #(
		.WAYS (WAYS)
	) u_icache_top (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.req_ready (req_ready),
		.rsp       (rsp),
		.mem_req   (mem_req),
		.mem_rsp   (mem_rsp)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic word_t mem_word(input word_t a);
		return (a ^ 32'hc3a5_0000) + (a >> 2);
	endfunction

	function automatic word_t line_base(input word_t a);
		return a & ~word_t'(LINE_WORDS * 4 - 1);
	endfunction

	// taps 32 22 2 1
	function automatic logic lfsr_bit(inout logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		s = {s[30:0], fb};
		return fb;
	endfunction

	task automatic print_counts();
		$display("errors %0d, data errors %0d, fetches %0d, responses %0d, refills %0d",
			errors, rsp_errors, acc_cnt, rsp_cnt, ar_cnt);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic abort(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
		timed_out = 1'b1;
		// hold the caller here until the watchdog ends the run
		forever @(posedge clk);
	endtask

	initial begin
		wait (timed_out);
		print_counts();
		$display("Simulation failed");
		$finish;
	end

	task automatic check_word(input word_t got, input word_t exp, input word_t addr);
		if (got !== exp) begin
			rsp_errors++;
			$display("FAIL %0t: fetch %h returned %h, expected %h", $time, addr, got, exp);
		end
	endtask

	task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
		if (got.ar_addr !== exp.ar_addr || got.ar_len !== exp.ar_len) begin
			errors++;
			$display("FAIL %0t: AR addr %h len %0d, expected addr %h len %0d", $time,
				got.ar_addr, got.ar_len, exp.ar_addr, exp.ar_len);
		end
	endtask

	// responses come back in fetch order
	always @(negedge clk) begin
		if (!rst) begin
			if (rsp.valid) begin
				if (exp_q.size() == 0) begin
					rsp_errors++;
					$display("ERROR at %0t: response with no fetch outstanding", $time);
				end else begin
					rsp_addr = exp_q.pop_front();
					lat_q.push_back(cycle - acc_q.pop_front());
					rsp_cnt++;
					check_word(rsp.data, mem_word(rsp_addr), rsp_addr);
				end
			end
			if (req_valid && req_ready) begin
				exp_q.push_back(req_addr.raw);
				acc_q.push_back(cycle);
				acc_cnt++;
			end
		end
	end

	// memory, sampled mid-cycle and driven just after the edge
	always begin
		@(negedge clk);
		ar_req = mem_req;
		ar_fire = mem_req.ar_valid && mem_rsp.ar_ready;
		r_fire = mem_req.r_ready && mem_rsp.r_valid;
		@(posedge clk);
		#5;
		if (rst) begin
			busy = 1'b0;
		end else if (ar_fire) begin
			ar_cnt++;
			ar_log.push_back(ar_req);
			burst_addr = ar_req.ar_addr;
			burst_len = int'(ar_req.ar_len);
			beat = 0;
			busy = 1'b1;
		end else if (r_fire) begin
			busy = (beat != burst_len);
			beat++;
		end
		stall = stall_en ? lfsr_bit(stall_lfsr) : 1'b0;
		mem_rsp.ar_ready = !busy && !stall;
		mem_rsp.r_valid = busy && !stall;
		mem_rsp.r_data = mem_word(burst_addr + word_t'(beat) * 4);
		mem_rsp.r_last = busy && (beat == burst_len);
	end

	task automatic fetch(input word_t addr, output int waits);
		int n;
		n = 0;
		@(posedge clk);
		#5;
		req_valid = 1'b1;
		req_addr.raw = addr;
		@(negedge clk);
		while (!req_ready) begin
			if (n == TIMEOUT) abort($sformatf("fetch %h was never accepted", addr));
			n++;
			@(negedge clk);
		end
		waits = n;
	endtask

	task automatic drain();
		int n;
		n = 0;
		@(posedge clk);
		#5;
		req_valid = 1'b0;
		while (rsp_cnt != acc_cnt) begin
			if (n == TIMEOUT) abort("fetch responses still missing after the timeout");
			n++;
			@(posedge clk);
		end
	endtask

	task automatic reset_sweep();
		int low;
		low = 0;
		// rst is seen high on 16 rising edges
		repeat (15) begin
			@(negedge clk);
			if (req_ready || mem_req.ar_valid || mem_req.r_ready || rsp.valid) begin
				report_error("handshake output high during reset");
			end
		end
		@(posedge clk);
		#5;
		rst = 1'b0;
		@(negedge clk);
		while (!req_ready) begin
			if (mem_req.ar_valid || mem_req.r_ready || rsp.valid) begin
				report_error("memory request or response during the invalidation sweep");
			end
			if (low == TIMEOUT) abort("req_ready never rose after reset");
			low++;
			@(negedge clk);
		end
		if (low < SETS) begin
			report_error($sformatf("req_ready rose %0d cycles after reset", low));
		end
	endtask

	task automatic cold_miss();
		int ar_start;
		int waits;
		mem_req_t exp;
		exp = '0;
		exp.ar_addr = line_base(COLD_ADDR);
		exp.ar_len = 8'd7;
		ar_start = ar_cnt;
		fetch(COLD_ADDR, waits);
		drain();
		if (ar_cnt != ar_start + 1) begin
			report_error($sformatf("cold miss made %0d refills", ar_cnt - ar_start));
		end else begin
			check_mem_req(ar_log[ar_log.size() - 1], exp);
		end
	endtask

	task automatic hit_after_fill();
		int ar_start;
		int first;
		int waits;
		ar_start = ar_cnt;
		for (int w = 0; w < LINE_WORDS; w++) begin
			if (w != int'(COLD_ADDR[4:2])) begin
				first = lat_q.size();
				fetch(line_base(COLD_ADDR) + word_t'(w) * 4, waits);
				drain();
				if (lat_q.size() != first + 1 || lat_q[first] != 2) begin
					report_error("hit response not two cycles after acceptance");
				end
			end
		end
		if (ar_cnt != ar_start) report_error("refill issued for a hit");
	endtask

	task automatic streaming_hits();
		int ar_start;
		int first;
		int waits;
		int stalls;
		ar_start = ar_cnt;
		first = lat_q.size();
		stalls = 0;
		for (int w = 0; w < LINE_WORDS; w++) begin
			fetch(line_base(COLD_ADDR) + word_t'(LINE_WORDS - 1 - w) * 4, waits);
			stalls += waits;
		end
		drain();
		if (stalls != 0) report_error("streaming hits were not accepted every cycle");
		for (int i = first; i < lat_q.size(); i++) begin
			if (lat_q[i] != 2) report_error("streaming hit responses not on consecutive cycles");
		end
		if (ar_cnt != ar_start) report_error("refill issued while streaming hits");
	endtask

	task automatic conflict_set();
		fetch_addr_t a;
		mem_req_t exp;
		int ar_start;
		int first;
		int waits;
		int refills;
		exp = '0;
		exp.ar_len = 8'd7;
		refills = 0;
		for (int pass = 0; pass < 2; pass++) begin
			for (int k = 0; k < 6; k++) begin
				a = '0;
				a.f.tag = tag_t'(k + 1);
				a.f.index = CONFLICT_INDEX;
				a.f.offset = offset_t'(k);
				ar_start = ar_cnt;
				first = lat_q.size();
				fetch(a.raw, waits);
				drain();
				exp.ar_addr = line_base(a.raw);
				if (ar_cnt == ar_start + 1) begin
					check_mem_req(ar_log[ar_log.size() - 1], exp);
					refills += pass;
				end else if (ar_cnt != ar_start || pass == 0 || lat_q[first] != 2) begin
					report_error($sformatf("conflict line %0d pass %0d: %0d refills, latency %0d",
						k, pass, ar_cnt - ar_start, lat_q[first]));
				end
			end
		end
		// only WAYS of the six lines fit in the set
		if (refills < 6 - WAYS) report_error("too few refills when re-fetching the conflict set");
	endtask

	task automatic random_fetches();
		word_t addrs[200];
		word_t r;
		int ar_start;
		int waits;
		for (int i = 0; i < 200; i++) begin
			r = '0;
			repeat (12) begin
				r = {r[30:0], lfsr_bit(addr_lfsr)};
			end
			addrs[i] = RAND_BASE | (r << 2);
		end
		ar_start = ar_cnt;
		stall_en = 1'b1;
		foreach (addrs[i]) begin
			fetch(addrs[i], waits);
		end
		drain();
		stall_en = 1'b0;
		if (ar_cnt - ar_start > 200) report_error("more refills than random fetches");
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		reset_sweep();
		cold_miss();
		hit_after_fill();
		streaming_hits();
		conflict_set();
		random_fetches();
		if (ar_cnt > acc_cnt) report_error("more refills than fetches");
		print_counts();
		if (errors + rsp_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
